// ==== sim.f ====
rtl/cpu_pkg.sv
rtl/stage_result_if.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/cpu_top.sv
tb/isa_model.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A failing check ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--timescale 1ns/1ps \
	--top-module tb_cpu \
	--Mdir obj_dir \
	-o tb_cpu_sim \
	-f sim.f

./obj_dir/tb_cpu_sim

// ==== tb/tb_cpu.sv ====
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int QUIET_CYCLES = 20;
	// four cycles per instruction covers stalls and squashed slots
	localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 200 + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h1a6fc9b6;
	localparam word_t HALT_ADDR = 16'(PROG_LEN);
	// beq r0, r0 with offset 0
	localparam word_t HALT_WORD = 16'hc000;
	// cpu_top default reset pc
	localparam word_t START_PC = 16'h0000;

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	word_t dmem_rdata;
	logic wb_en;
	reg_idx_t wb_dest;
	word_t wb_data;

	word_t imem [256];
	word_t dmem [256];
	word_t dmem_init [256];
	logic [8:0] last_mem_ref;
	logic [7:0] writes_seen;
	logic [7:0] stores_seen;
	logic halt_seen;

	cpu_top i_cpu_top (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.wb_data(wb_data)
	);

	isa_model i_isa_model ();

	//////////////////////////////
	// memories
	//////////////////////////////

	// both answer in the same cycle
	assign imem_data = (imem_addr < 16'd256) ? imem[imem_addr[7:0]] : HALT_WORD;
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	always @(posedge clk) begin
		if (reset)
			dmem <= dmem_init;
		else if (dmem_we)
			dmem[dmem_addr[7:0]] <= dmem_wdata;
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// one instruction of the kept subset at address pc
	function automatic word_t random_instr(input int pc);
		logic [31:0] r;
		word_t iw;
		int offset;
		r = $urandom();
		iw = r[15:0];
		// forward 1 to 8 and never past the halt
		offset = int'(r[21:19]) + 1;
		if (pc + offset > PROG_LEN)
			offset = PROG_LEN - pc;
		case (r[18:16])
			3'd0: iw[15:12] = ADD;
			3'd1: iw[15:12] = ADI;
			3'd2: iw[15:12] = NDU;
			3'd3: iw[15:12] = LHI;
			3'd4: iw[15:12] = LW;
			3'd5: iw[15:12] = SW;
			3'd6: begin
				iw[15:12] = BEQ;
				iw[5:0] = 6'(offset);
			end
			default: begin
				iw[15:12] = JAL;
				iw[8:0] = 9'(offset);
			end
		endcase
		// reuse base and offset of the last memory op half the time
		if (iw[15:12] == LW || iw[15:12] == SW) begin
			if (r[22])
				iw[8:0] = last_mem_ref;
			last_mem_ref = iw[8:0];
		end
		return iw;
	endfunction

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic end_in_failure();
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_reg_write(input reg_idx_t got_dest, input word_t got_data,
		input reg_idx_t exp_dest, input word_t exp_data);
		if (got_dest !== exp_dest) begin
			$display("** Error at %0t: wb_dest = %0d, expected %0d", $time, got_dest, exp_dest);
			end_in_failure();
		end else if (got_data !== exp_data) begin
			$display("** Error at %0t: wb_data = %h, expected %h", $time, got_data, exp_data);
			end_in_failure();
		end
	endtask

	task automatic check_store(input word_t got_addr, input word_t got_data,
		input word_t exp_addr, input word_t exp_data);
		if (got_addr !== exp_addr) begin
			$display("** Error at %0t: dmem_addr = %h, expected %h", $time, got_addr, exp_addr);
			end_in_failure();
		end else if (got_data !== exp_data) begin
			$display("** Error at %0t: dmem_wdata = %h, expected %h", $time, got_data,
				exp_data);
			end_in_failure();
		end
	endtask

	task automatic check_fetch_addr(input word_t got_addr, input word_t exp_addr);
		if (got_addr !== exp_addr) begin
			$display("** Error at %0t: imem_addr = %h, expected %h", $time, got_addr, exp_addr);
			end_in_failure();
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (imem_addr >= HALT_ADDR)
				halt_seen = 1'b1;
			if (wb_en) begin
				if (writes_seen == i_isa_model.n_writes) begin
					$display("at %0t ns a register write came after the last expected one", $time);
					end_in_failure();
				end else begin
					check_reg_write(wb_dest, wb_data, i_isa_model.exp_dest[writes_seen],
						i_isa_model.exp_value[writes_seen]);
					writes_seen = writes_seen + 8'd1;
				end
			end
			if (dmem_we) begin
				if (stores_seen == i_isa_model.n_stores) begin
					$display("at %0t ns a store came after the last expected one", $time);
					end_in_failure();
				end else begin
					check_store(dmem_addr, dmem_wdata, i_isa_model.exp_addr[stores_seen],
						i_isa_model.exp_data[stores_seen]);
					stores_seen = stores_seen + 8'd1;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("program did not reach halt within %0d cycles", TIMEOUT_CYCLES);
		end_in_failure();
	end

	initial begin
		logic [31:0] r;
		void'($urandom(SEED));
		reset <= 1'b1;
		last_mem_ref = '0;
		writes_seen = '0;
		stores_seen = '0;
		halt_seen = 1'b0;
		// program followed by halt words to the end
		for (int i = 0; i < 256; i++) begin
			r = $urandom();
			imem[8'(i)] = (i < PROG_LEN) ? random_instr(i) : HALT_WORD;
			dmem_init[8'(i)] = r[15:0];
			i_isa_model.imem[8'(i)] = imem[8'(i)];
			i_isa_model.dmem[8'(i)] = r[15:0];
		end
		i_isa_model.run(HALT_ADDR);
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// first fetch out of reset
		@(negedge clk);
		check_fetch_addr(imem_addr, START_PC);
		while (writes_seen != i_isa_model.n_writes || stores_seen != i_isa_model.n_stores
			|| !halt_seen)
			@(posedge clk);
		// halt loop must stay silent
		repeat (QUIET_CYCLES) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/isa_model.sv ====
`default_nettype none

module isa_model;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;

	// memory contents as the program starts
	word_t imem [256];
	word_t dmem [256];
	word_t regs [8];

	//////////////////////////////
	// expected results
	//////////////////////////////

	// register writes and stores in program order
	reg_idx_t exp_dest [256];
	word_t exp_value [256];
	word_t exp_addr [256];
	word_t exp_data [256];
	logic [7:0] n_writes;
	logic [7:0] n_stores;

	task automatic commit_write(input reg_idx_t dest, input word_t value);
		regs[dest] = value;
		exp_dest[n_writes] = dest;
		exp_value[n_writes] = value;
		n_writes = n_writes + 8'd1;
	endtask

	// data memory wraps on the low 8 address bits
	task automatic commit_store(input word_t addr, input word_t data);
		dmem[addr[7:0]] = data;
		exp_addr[n_stores] = addr;
		exp_data[n_stores] = data;
		n_stores = n_stores + 8'd1;
	endtask

	// one instruction per step until the pc reaches the halt
	task automatic run(input word_t halt_pc);
		word_t pc;
		word_t next_pc;
		word_t iw;
		word_t a;
		word_t b;
		word_t off6;
		word_t off9;
		word_t addr;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		opcode_e op;
		pc = '0;
		regs = '{default: '0};
		n_writes = '0;
		n_stores = '0;
		// offsets are forward only, so this ends
		while (pc < halt_pc) begin
			iw = imem[pc[7:0]];
			op = opcode_e'(iw[15:12]);
			ra = iw[11:9];
			rb = iw[8:6];
			rc = iw[5:3];
			a = regs[ra];
			b = regs[rb];
			off6 = word_t'($signed(iw[5:0]));
			off9 = word_t'($signed(iw[8:0]));
			addr = b + off6;
			next_pc = pc + 16'd1;
			case (op)
				ADD: commit_write(rc, a + b);
				ADI: commit_write(rb, a + off6);
				NDU: commit_write(rc, ~(a & b));
				LHI: commit_write(ra, {iw[8:0], 7'd0});
				LW: commit_write(ra, dmem[addr[7:0]]);
				SW: commit_store(addr, a);
				JAL: begin
					// link is the next sequential pc
					commit_write(ra, pc + 16'd1);
					next_pc = pc + off9;
				end
				BEQ: begin
					if (a == b)
						next_pc = pc + off6;
				end
				default: ;
			endcase
			pc = next_pc;
		end
	endtask

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset,
	output cpu_pkg::word_t imem_addr,
	input wire cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t dmem_addr,
	output cpu_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input wire cpu_pkg::word_t dmem_rdata,
	output logic wb_en,
	output cpu_pkg::reg_idx_t wb_dest,
	output cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	// pending results seen by decode
	stage_result_if ex_res();
	stage_result_if mem_res();
	stage_result_if wb_res();

	// fetch/decode
	logic if_valid;
	word_t if_pc;
	word_t if_pc_plus1;
	instr_u if_instr;

	// hazard and redirect strobes
	logic stall;
	logic id_redirect;
	word_t id_target;
	logic ex_redirect;
	word_t ex_target;

	// decode/execute
	logic id_valid;
	instr_u id_instr;
	word_t op_a;
	word_t op_b;
	word_t id_pc;
	word_t id_pc_plus1;

	// execute/memory
	logic mem_valid;
	instr_u mem_instr;
	word_t mem_alu;
	word_t mem_store_data;

	fetch_stage #(.RESET_PC(RESET_PC)) i_fetch_stage (.*);

	decode_stage i_decode_stage (.*);

	execute_stage i_execute_stage (.*);

	memory_writeback i_memory_writeback (.*);

	assign wb_en = wb_res.wr_en;
	assign wb_dest = wb_res.dest;
	assign wb_data = wb_res.value;

endmodule

`default_nettype wire

// ==== rtl/memory_writeback.sv ====
`default_nettype none

module memory_writeback (
	input wire clk,
	input wire reset,
	input wire mem_valid,
	input wire cpu_pkg::instr_u mem_instr,
	input wire cpu_pkg::word_t mem_alu,
	input wire cpu_pkg::word_t mem_store_data,
	output cpu_pkg::word_t dmem_addr,
	output cpu_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input wire cpu_pkg::word_t dmem_rdata,
	stage_result_if.producer mem_res,
	stage_result_if.producer wb_res
);
	import cpu_pkg::*;

	opcode_e op;
	logic is_load;
	logic wb_wr_en;
	reg_idx_t wb_dest;
	word_t wb_value;
	logic wb_is_load;

	assign op = mem_instr.r.opcode;
	assign is_load = op == LW;

	// data memory answers in the same cycle
	assign dmem_addr = mem_alu;
	assign dmem_wdata = mem_store_data;
	assign dmem_we = mem_valid && op == SW;

	// lw picks up the read data here
	assign mem_res.wr_en = mem_valid && writes_reg(mem_instr);
	assign mem_res.dest = dest_reg(mem_instr);
	assign mem_res.value = is_load ? dmem_rdata : mem_alu;
	assign mem_res.is_load = is_load;

	//////////////////////////////
	// memory/writeback register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			wb_wr_en <= 1'b0;
		else
			wb_wr_en <= mem_res.wr_en;
	end

	always_ff @(posedge clk) begin
		wb_dest <= mem_res.dest;
		wb_value <= mem_res.value;
		wb_is_load <= is_load;
	end

	// commit port, also the register file write
	assign wb_res.wr_en = wb_wr_en;
	assign wb_res.dest = wb_dest;
	assign wb_res.value = wb_value;
	assign wb_res.is_load = wb_is_load;

	// a store never also claims a register
	assert property (@(posedge clk) disable iff (reset) dmem_we |-> !mem_res.wr_en);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input wire clk,
	input wire reset,
	input wire id_valid,
	input wire cpu_pkg::instr_u id_instr,
	input wire cpu_pkg::word_t op_a,
	input wire cpu_pkg::word_t op_b,
	input wire cpu_pkg::word_t id_pc,
	input wire cpu_pkg::word_t id_pc_plus1,
	stage_result_if.producer ex_res,
	output logic ex_redirect,
	output cpu_pkg::word_t ex_target,
	output logic mem_valid,
	output cpu_pkg::instr_u mem_instr,
	output cpu_pkg::word_t mem_alu,
	output cpu_pkg::word_t mem_store_data
);
	import cpu_pkg::*;

	opcode_e op;
	word_t imm6;
	word_t result;

	assign op = id_instr.r.opcode;
	assign imm6 = sign_ext6(id_instr.i6.imm6);

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (op)
			ADD: result = op_a + op_b;
			ADI: result = op_a + imm6;
			NDU: result = ~(op_a & op_b);
			// upper nine bits, low seven cleared
			LHI: result = {id_instr.i9.imm9, 7'b0};
			// address is rb plus offset
			LW, SW: result = op_b + imm6;
			// link value
			JAL: result = id_pc_plus1;
			default: result = '0;
		endcase
	end

	// loads go out with the address, mem replaces it
	assign ex_res.wr_en = id_valid && writes_reg(id_instr);
	assign ex_res.dest = dest_reg(id_instr);
	assign ex_res.value = result;
	assign ex_res.is_load = op == LW;

	// beq offset is relative to its own pc
	assign ex_redirect = id_valid && op == BEQ && op_a == op_b;
	assign ex_target = id_pc + imm6;

	//////////////////////////////
	// execute/memory register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			mem_valid <= 1'b0;
		else
			mem_valid <= id_valid;
	end

	// store data is ra
	always_ff @(posedge clk) begin
		mem_instr <= id_instr;
		mem_alu <= result;
		mem_store_data <= op_a;
	end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage (
	input wire clk,
	input wire reset,
	input wire if_valid,
	input wire cpu_pkg::word_t if_pc,
	input wire cpu_pkg::word_t if_pc_plus1,
	input wire cpu_pkg::instr_u if_instr,
	stage_result_if.consumer ex_res,
	stage_result_if.consumer mem_res,
	stage_result_if.consumer wb_res,
	input wire ex_redirect,
	output logic stall,
	output logic id_redirect,
	output cpu_pkg::word_t id_target,
	output logic id_valid,
	output cpu_pkg::instr_u id_instr,
	output cpu_pkg::word_t op_a,
	output cpu_pkg::word_t op_b,
	output cpu_pkg::word_t id_pc,
	output cpu_pkg::word_t id_pc_plus1
);
	import cpu_pkg::*;

	reg_idx_t src_a;
	reg_idx_t src_b;
	word_t rf_a;
	word_t rf_b;
	word_t fwd_a;
	word_t fwd_b;
	logic uses_a;
	logic uses_b;
	logic hazard_a;
	logic hazard_b;
	logic bubble;

	// ra and rb sit in the same bits in every format
	assign src_a = if_instr.r.ra;
	assign src_b = if_instr.r.rb;

	register_file i_register_file (
		.clk(clk),
		.reset(reset),
		.rd_a(src_a),
		.rd_b(src_b),
		.data_a(rf_a),
		.data_b(rf_b),
		.wr(wb_res)
	);

	// only real sources may stall
	always_comb begin
		uses_a = 1'b0;
		uses_b = 1'b0;
		case (if_instr.r.opcode)
			ADD, NDU, BEQ, SW: begin
				uses_a = 1'b1;
				uses_b = 1'b1;
			end
			ADI: uses_a = 1'b1;
			// base register only
			LW: uses_b = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////
	// forwarding
	//////////////////////////////

	// youngest producer first
	function automatic word_t forward(input reg_idx_t src, input word_t rf_val);
		if (ex_res.wr_en && !ex_res.is_load && ex_res.dest == src)
			return ex_res.value;
		if (mem_res.wr_en && mem_res.dest == src)
			return mem_res.value;
		if (wb_res.wr_en && wb_res.dest == src)
			return wb_res.value;
		return rf_val;
	endfunction

	always_comb begin
		fwd_a = forward(src_a, rf_a);
		fwd_b = forward(src_b, rf_b);
	end

	// load data shows up one stage later, wait a cycle
	assign hazard_a = uses_a && ex_res.dest == src_a;
	assign hazard_b = uses_b && ex_res.dest == src_b;
	assign stall = if_valid && ex_res.wr_en && ex_res.is_load && (hazard_a || hazard_b);

	// jal target known here, one slot lost
	assign id_redirect = if_valid && if_instr.i9.opcode == JAL;
	assign id_target = if_pc + sign_ext9(if_instr.i9.imm9);

	//////////////////////////////
	// decode/execute register
	//////////////////////////////

	assign bubble = stall || ex_redirect;

	always_ff @(posedge clk) begin
		if (reset)
			id_valid <= 1'b0;
		else
			id_valid <= if_valid && !bubble;
	end

	always_ff @(posedge clk) begin
		if (bubble)
			id_instr <= NOP_WORD;
		else
			id_instr <= if_instr;
		op_a <= fwd_a;
		op_b <= fwd_b;
		id_pc <= if_pc;
		id_pc_plus1 <= if_pc_plus1;
	end

	// jal reads no register, so it never waits on a load
	assert property (@(posedge clk) disable iff (reset) !(stall && id_redirect));

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none

module register_file (
	input wire clk,
	input wire reset,
	input wire cpu_pkg::reg_idx_t rd_a,
	input wire cpu_pkg::reg_idx_t rd_b,
	output cpu_pkg::word_t data_a,
	output cpu_pkg::word_t data_b,
	stage_result_if.consumer wr
);
	import cpu_pkg::*;

	// all eight general, no hardwired pc or zero
	word_t regs [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wr.wr_en) begin
			regs[wr.dest] <= wr.value;
		end
	end

	// old value during a same-cycle write
	// decode forwards from wb to cover it
	assign data_a = regs[rd_a];
	assign data_b = regs[rd_b];

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none

module fetch_stage #(
	parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset,
	input wire stall,
	input wire id_redirect,
	input wire cpu_pkg::word_t id_target,
	input wire ex_redirect,
	input wire cpu_pkg::word_t ex_target,
	output cpu_pkg::word_t imem_addr,
	input wire cpu_pkg::word_t imem_data,
	output logic if_valid,
	output cpu_pkg::word_t if_pc,
	output cpu_pkg::word_t if_pc_plus1,
	output cpu_pkg::instr_u if_instr
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus1;
	word_t pc_next;
	logic flush;

	assign pc_plus1 = pc + 16'd1;
	assign imem_addr = pc;
	// either redirect kills the word fetched this cycle
	assign flush = ex_redirect || id_redirect;

	// beq in ex is older than jal in id, so it wins
	always_comb begin
		if (ex_redirect)
			pc_next = ex_target;
		else if (id_redirect)
			pc_next = id_target;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc_plus1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	//////////////////////////////
	// fetch/decode register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			if_valid <= 1'b0;
		else if (flush)
			if_valid <= 1'b0;
		else if (!stall)
			if_valid <= 1'b1;
	end

	// held while decode waits on a load
	always_ff @(posedge clk) begin
		if (flush) begin
			if_instr <= NOP_WORD;
		end else if (!stall) begin
			if_instr <= imem_data;
			if_pc <= pc;
			if_pc_plus1 <= pc_plus1;
		end
	end

	// load-use in ex and a taken beq in ex are never the same slot
	assert property (@(posedge clk) disable iff (reset) !(stall && ex_redirect));

endmodule

`default_nettype wire

// ==== rtl/stage_result_if.sv ====
`default_nettype none

interface stage_result_if;
	import cpu_pkg::*;

	// stage holds a valid instr that writes dest
	logic wr_en;
	reg_idx_t dest;
	// result as far as this stage knows it
	word_t value;
	// load data not yet available when seen from ex
	logic is_load;

	modport producer (
		output wr_en,
		output dest,
		output value,
		output is_load
	);

	modport consumer (
		input wr_en,
		input dest,
		input value,
		input is_load
	);

endinterface

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	//////////////////////////////
	// basic types
	//////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	typedef enum logic [3:0] {
		ADD = 4'b0000,
		ADI = 4'b0001,
		NDU = 4'b0010,
		LHI = 4'b0011,
		LW  = 4'b0100,
		SW  = 4'b0101,
		JAL = 4'b1000,
		BEQ = 4'b1100
	} opcode_e;

	// register format, cz bits carried but ignored
	typedef struct packed {
		opcode_e opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		logic [2:0] cz;
	} r_fmt_t;

	// adi, lw, sw, beq
	typedef struct packed {
		opcode_e opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		logic [5:0] imm6;
	} i6_fmt_t;

	// lhi, jal
	typedef struct packed {
		opcode_e opcode;
		reg_idx_t ra;
		logic [8:0] imm9;
	} i9_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i6_fmt_t i6;
		i9_fmt_t i9;
	} instr_u;

	// opcode 1111 decodes as a no-op
	localparam word_t NOP_WORD = 16'hffff;

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic word_t sign_ext6(input logic [5:0] imm);
		return {{10{imm[5]}}, imm};
	endfunction

	function automatic word_t sign_ext9(input logic [8:0] imm);
		return {{7{imm[8]}}, imm};
	endfunction

	// sw, beq and unknown opcodes leave the register file alone
	function automatic logic writes_reg(input instr_u instr);
		case (instr.r.opcode)
			ADD, ADI, NDU, LHI, LW, JAL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// destination field moves with the format
	function automatic reg_idx_t dest_reg(input instr_u instr);
		case (instr.r.opcode)
			ADD, NDU: return instr.r.rc;
			ADI: return instr.i6.rb;
			default: return instr.r.ra;
		endcase
	endfunction

endpackage

`default_nettype wire
